// File: build.f
rtl/arm_dp_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/alu_unit.sv
rtl/barrel_shifter.sv
rtl/writeback_stage.sv
rtl/arm_dp_core.sv
sim/arm_dp_checker.sv
sim/arm_dp_core_sva.sv
sim/tb_arm_dp_core.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_arm_dp_core
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "run FAILED, see $(LOG)"; exit 1; }
	@echo "run PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/arm_dp_trace.txt
# valid instr rd result nzcv, all hex
# rd, result and nzcv are the expected outputs, unused when no result is due
0 00000000 0 00000000 0
1 E1A01002 1 00000000 0
1 E3A02080 2 00000080 0
1 E2823005 3 00000085 0
1 E2534085 4 00000000 6
1 E2725010 5 FFFFFF90 8
1 E20560F0 6 00000090 8
1 E386700F 7 0000009F 8
1 E23780FF 8 00000060 0
1 E3F09000 9 FFFFFFFF 8
1 E299A001 A 00000000 6
1 E1A0B0A9 B 7FFFFFFF 6
1 E29BC001 C 80000000 9
1 E1B0DFAC D 00000001 1
1 E1A0E24C E F8000000 1
1 E1A01E07 1 F0000000 1
1 E1A02267 2 F0000009 1
1 E3533055 0 00000000 0
1 E0834002 4 F000008E 1
0 00000000 0 00000000 0
1 E1A05064 5 F000008E 1
1 E0556004 6 00000000 6

// File: sim/tb_arm_dp_core.sv
`timescale 1ns/100ps

module tb_arm_dp_core import arm_dp_pkg::*; ();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 10;
    localparam int    PIPE_LATENCY = 2;
    localparam int    DRAIN_CYCLES = 8;
    localparam int    SLACK_CYCLES = 20;
    localparam string TRACE_FILE   = "sim/arm_dp_trace.txt";

    logic                  clk   = 1'b0;
    logic                  reset = 1'b1;
    logic                  instr_valid;
    logic [DATA_W-1:0]     instr;
    logic                  result_valid;
    logic [DATA_W-1:0]     result;
    logic [REG_ADDR_W-1:0] result_rd;
    logic [3:0]            flags;
    logic                  exp_push;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [DATA_W-1:0]     exp_result;
    logic [3:0]            exp_flags;
    int                    check_count;
    int                    mismatch_count;
    int                    unexpected_count;
    int                    pending;
    int                    cycle_count   = 0;
    int                    timeout_limit = 1000;

    // one entry per trace line
    logic                  trace_valid  [$];
    logic [DATA_W-1:0]     trace_instr  [$];
    logic [REG_ADDR_W-1:0] trace_rd     [$];
    logic [DATA_W-1:0]     trace_result [$];
    logic [3:0]            trace_flags  [$];

    arm_dp_core arm_dp_core_i (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr),
        .result_valid(result_valid), .result(result), .result_rd(result_rd),
        .flags(flags)
    );

    arm_dp_checker arm_dp_checker_i (
        .clk(clk), .reset(reset),
        .result_valid(result_valid), .result(result), .result_rd(result_rd),
        .flags(flags),
        .exp_push(exp_push), .exp_rd(exp_rd), .exp_result(exp_result),
        .exp_flags(exp_flags),
        .check_count(check_count), .mismatch_count(mismatch_count),
        .unexpected_count(unexpected_count), .pending(pending)
    );

    bind arm_dp_core arm_dp_core_sva sva_i (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .result_valid(result_valid), .flags(flags)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ARM data-processing encodings of AND EOR SUB RSB ADD ORR MOV MVN
    function automatic logic is_supported_opcode(input logic [3:0] opcode);
        case (opcode)
            4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'hC, 4'hD, 4'hF: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int load_trace();
        int                fd;
        int                n;
        string             line;
        logic [DATA_W-1:0] v;
        logic [DATA_W-1:0] ins;
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] res;
        logic [DATA_W-1:0] fl;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            return 0;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip header lines
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", v, ins, rd, res, fl);
                if (n == 5) begin
                    trace_valid.push_back(v[0]);
                    trace_instr.push_back(ins);
                    trace_rd.push_back(rd[REG_ADDR_W-1:0]);
                    trace_result.push_back(res);
                    trace_flags.push_back(fl[3:0]);
                end
            end
        end
        $fclose(fd);
        return trace_instr.size();
    endfunction

    task automatic run_trace();
        int drain_cycles;
        drain_cycles = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < trace_instr.size(); i++) begin
            @(posedge clk);
            #1;
            instr_valid = trace_valid[i];
            instr       = trace_instr[i];
            exp_push    = trace_valid[i] && is_supported_opcode(trace_instr[i][OPCODE_LSB +: 4]);
            exp_rd      = trace_rd[i];
            exp_result  = trace_result[i];
            exp_flags   = trace_flags[i];
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        exp_push    = 1'b0;
        // let the outstanding results come out
        while (pending != 0 && drain_cycles < DRAIN_CYCLES) begin
            @(negedge clk);
            #1;
            drain_cycles++;
        end
        // short tail for stray results
        repeat (PIPE_LATENCY) @(posedge clk);
        @(negedge clk);
        #1;
    endtask

    task automatic report_and_finish();
        int total;
        total = mismatch_count + unexpected_count + pending;
        if (pending != 0) begin
            $display("error: %0d expected results never appeared", pending);
        end
        if (check_count == 0) begin
            $display("error: no results were checked");
            total++;
        end
        $display("checks %0d, mismatches %0d, unexpected results %0d, missing results %0d",
                 check_count, mismatch_count, unexpected_count, pending);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        exp_push    = 1'b0;
        exp_rd      = '0;
        exp_result  = '0;
        exp_flags   = '0;
        if (load_trace() == 0) begin
            $display("error: no stimulus lines could be read from %s", TRACE_FILE);
            $display("Simulation failed");
            $finish;
        end else begin
            timeout_limit = RESET_CYCLES + trace_instr.size() + PIPE_LATENCY + SLACK_CYCLES;
            run_trace();
            report_and_finish();
        end
    end

endmodule

// File: sim/arm_dp_core_sva.sv
`timescale 1ns/100ps

module arm_dp_core_sva import arm_dp_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              instr_valid,
    input logic [DATA_W-1:0] instr,
    input logic              result_valid,
    input logic [3:0]        flags
);

    logic supported_in;

    assign supported_in = instr[OPCODE_LSB +: 4] inside
        {OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ORR, OP_MOV, OP_MVN};

    result_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(result_valid))
        else $error("result_valid is unknown");

    // flags and result_valid load on the same edge
    flags_follow_result: assert property (@(posedge clk) disable iff (reset)
        $changed(flags) |-> result_valid)
        else $error("flags changed without a result");

    // output registered at the second edge, so seen on the third sample
    result_latency: assert property (@(posedge clk) disable iff (reset)
        instr_valid && supported_in |-> ##3 result_valid)
        else $error("no result two cycles after an accepted instruction");

endmodule

// File: sim/arm_dp_checker.sv
`timescale 1ns/100ps

module arm_dp_checker import arm_dp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  result_valid,
    input  logic [DATA_W-1:0]     result,
    input  logic [REG_ADDR_W-1:0] result_rd,
    input  logic [3:0]            flags,
    input  logic                  exp_push,
    input  logic [REG_ADDR_W-1:0] exp_rd,
    input  logic [DATA_W-1:0]     exp_result,
    input  logic [3:0]            exp_flags,
    output int                    check_count,
    output int                    mismatch_count,
    output int                    unexpected_count,
    output int                    pending
);

    // entry layout {rd, result, nzcv}
    logic [REG_ADDR_W+DATA_W+3:0] expected_q [$];
    logic [REG_ADDR_W+DATA_W+3:0] entry;
    logic                         out_of_reset = 1'b0;

    task automatic compare_field(input string name, input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            expected_q.delete();
            out_of_reset     = 1'b0;
            check_count      = 0;
            mismatch_count   = 0;
            unexpected_count = 0;
        end else begin
            if (!out_of_reset) begin
                out_of_reset = 1'b1;
                compare_field("flags", '0, DATA_W'(flags));
            end
            if (result_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    unexpected_count++;
                    $display("error at %0t: result_valid high with nothing outstanding", $time);
                end else begin
                    entry = expected_q.pop_front();
                    compare_field("result_rd", DATA_W'(entry[DATA_W+4 +: REG_ADDR_W]),
                                  DATA_W'(result_rd));
                    compare_field("result", entry[4 +: DATA_W], result);
                    compare_field("flags", DATA_W'(entry[3:0]), DATA_W'(flags));
                end
            end
            if (exp_push === 1'b1) begin
                expected_q.push_back({exp_rd, exp_result, exp_flags});
            end
        end
        pending = expected_q.size();
    end

endmodule

// File: rtl/arm_dp_core.sv
`timescale 1ns/100ps

module arm_dp_core import arm_dp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  logic [DATA_W-1:0]     instr,
    output logic                  result_valid,
    output logic [DATA_W-1:0]     result,
    output logic [REG_ADDR_W-1:0] result_rd,
    output logic [3:0]            flags
);

    logic [REG_ADDR_W-1:0] ra1;
    logic [REG_ADDR_W-1:0] ra2;
    logic [DATA_W-1:0]     rd1;
    logic [DATA_W-1:0]     rd2;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_data;
    logic                  ex_we;
    alu_op_t               ex_op;
    logic                  ex_set_flags;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [DATA_W-1:0]     ex_a;
    logic [DATA_W-1:0]     ex_b;
    shift_t                ex_shift;
    logic [SHAMT_W-1:0]    ex_shamt;
    logic                  ex_use_shifter;
    logic [DATA_W-1:0]     alu_y;
    logic                  alu_carry;
    logic                  alu_overflow;
    logic [DATA_W-1:0]     shift_y;

    ////////////////////////////////////////////////////////////////////////////
    // decode and register file
    reg_file reg_file_i (
        .clk(clk), .reset(reset),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .we(wb_we), .wa(wb_rd), .wd(wb_data)
    );

    decode_stage decode_stage_i (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_we(ex_we), .ex_op(ex_op), .ex_set_flags(ex_set_flags), .ex_rd(ex_rd),
        .ex_a(ex_a), .ex_b(ex_b), .ex_shift(ex_shift), .ex_shamt(ex_shamt),
        .ex_use_shifter(ex_use_shifter)
    );

    ////////////////////////////////////////////////////////////////////////////
    // execute, alu and shifter side by side
    alu_unit alu_unit_i (
        .a(ex_a), .b(ex_b), .op(ex_op), .flags(flags),
        .y(alu_y), .carry(alu_carry), .overflow(alu_overflow)
    );

    barrel_shifter barrel_shifter_i (
        .value(ex_b), .shift(ex_shift), .shamt(ex_shamt), .y(shift_y)
    );

    writeback_stage writeback_stage_i (
        .clk(clk), .reset(reset),
        .ex_we(ex_we), .ex_set_flags(ex_set_flags), .ex_rd(ex_rd),
        .ex_use_shifter(ex_use_shifter),
        .alu_y(alu_y), .alu_carry(alu_carry), .alu_overflow(alu_overflow),
        .shift_y(shift_y),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .result_valid(result_valid), .result(result), .result_rd(result_rd),
        .flags(flags)
    );

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage import arm_dp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ex_we,
    input  logic                  ex_set_flags,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic                  ex_use_shifter,
    input  logic [DATA_W-1:0]     alu_y,
    input  logic                  alu_carry,
    input  logic                  alu_overflow,
    input  logic [DATA_W-1:0]     shift_y,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [DATA_W-1:0]     wb_data,
    output logic                  result_valid,
    output logic [DATA_W-1:0]     result,
    output logic [REG_ADDR_W-1:0] result_rd,
    output logic [3:0]            flags
);

    logic [DATA_W-1:0] sel_y;
    logic [3:0]        flags_next;

    assign sel_y = ex_use_shifter ? shift_y : alu_y;

    // register file write and forwarding source
    assign wb_we   = ex_we;
    assign wb_rd   = ex_rd;
    assign wb_data = sel_y;

    // nz from the chosen result, cv only from the adder path
    always_comb begin
        flags_next         = flags;
        flags_next[FLAG_N] = sel_y[DATA_W-1];
        flags_next[FLAG_Z] = (sel_y == '0);
        if (!ex_use_shifter) begin
            flags_next[FLAG_C] = alu_carry;
            flags_next[FLAG_V] = alu_overflow;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
            flags        <= '0;
        end else begin
            result_valid <= ex_we;
            if (ex_we && ex_set_flags) begin
                flags <= flags_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        result    <= sel_y;
        result_rd <= ex_rd;
    end

endmodule

// File: rtl/barrel_shifter.sv
`timescale 1ns/100ps

module barrel_shifter import arm_dp_pkg::*; (
    input  logic [DATA_W-1:0]  value,
    input  shift_t             shift,
    input  logic [SHAMT_W-1:0] shamt,
    output logic [DATA_W-1:0]  y
);

    logic [DATA_W-1:0] stage [SHAMT_W+1];

    function automatic logic [DATA_W-1:0] bit_rev(input logic [DATA_W-1:0] v);
        logic [DATA_W-1:0] r;
        for (int i = 0; i < DATA_W; i++) begin
            r[i] = v[DATA_W-1-i];
        end
        return r;
    endfunction

    // everything shifts right, lsl runs on the bit-reversed word
    assign stage[0] = (shift == SH_LSL) ? bit_rev(value) : value;

    // stage i moves by 2**i when shamt bit i is set
    for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
        logic [(1<<i)-1:0] fill;

        always_comb begin
            case (shift)
                SH_ASR:  fill = {(1<<i){stage[i][DATA_W-1]}};
                SH_ROR:  fill = stage[i][(1<<i)-1:0];
                default: fill = '0;
            endcase
        end

        assign stage[i+1] = shamt[i] ? {fill, stage[i][DATA_W-1:(1<<i)]} : stage[i];
    end

    assign y = (shift == SH_LSL) ? bit_rev(stage[SHAMT_W]) : stage[SHAMT_W];

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/100ps

module alu_unit import arm_dp_pkg::*; (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  alu_op_t           op,
    input  logic [3:0]        flags,
    output logic [DATA_W-1:0] y,
    output logic              carry,
    output logic              overflow
);

    logic [DATA_W-1:0] add_x;
    logic [DATA_W-1:0] add_y;
    logic              add_cin;
    logic [DATA_W:0]   sum;
    logic              is_arith;

    // one adder serves add, sub and rsb
    // subtract as x + ~y + 1, carry set means no borrow
    always_comb begin
        add_x   = a;
        add_y   = b;
        add_cin = 1'b0;
        case (op)
            OP_SUB: begin
                add_y   = ~b;
                add_cin = 1'b1;
            end
            OP_RSB: begin
                add_x   = b;
                add_y   = ~a;
                add_cin = 1'b1;
            end
            default: ;
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {{DATA_W{1'b0}}, add_cin};

    always_comb begin
        case (op)
            OP_AND:  y = a & b;
            OP_EOR:  y = a ^ b;
            OP_ORR:  y = a | b;
            OP_MOV:  y = b;
            OP_MVN:  y = ~b;
            OP_SUB, OP_RSB, OP_ADD: y = sum[DATA_W-1:0];
            default: y = '0;
        endcase
    end

    // logical ops leave c and v as they were
    assign is_arith = (op == OP_ADD) || (op == OP_SUB) || (op == OP_RSB);
    assign carry    = is_arith ? sum[DATA_W] : flags[FLAG_C];
    assign overflow = is_arith ? ((add_x[DATA_W-1] == add_y[DATA_W-1]) &&
                                  (sum[DATA_W-1] != add_x[DATA_W-1]))
                               : flags[FLAG_V];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import arm_dp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  logic [DATA_W-1:0]     instr,
    output logic [REG_ADDR_W-1:0] ra1,
    output logic [REG_ADDR_W-1:0] ra2,
    input  logic [DATA_W-1:0]     rd1,
    input  logic [DATA_W-1:0]     rd2,
    input  logic                  wb_we,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [DATA_W-1:0]     wb_data,
    output logic                  ex_we,
    output alu_op_t               ex_op,
    output logic                  ex_set_flags,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [DATA_W-1:0]     ex_a,
    output logic [DATA_W-1:0]     ex_b,
    output shift_t                ex_shift,
    output logic [SHAMT_W-1:0]    ex_shamt,
    output logic                  ex_use_shifter
);

    logic                  instr_valid_q;
    logic [DATA_W-1:0]     instr_q;
    logic [3:0]            opcode;
    logic                  imm_sel;
    logic [SHAMT_W-1:0]    shamt;
    logic                  supported;
    logic [DATA_W-1:0]     opnd_a;
    logic [DATA_W-1:0]     opnd_rm;

    // instruction capture
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // field decode
    assign opcode  = instr_q[OPCODE_LSB +: 4];
    assign imm_sel = instr_q[IMM_BIT];
    assign shamt   = instr_q[SHAMT_LSB +: SHAMT_W];
    assign ra1     = instr_q[RN_LSB +: REG_ADDR_W];
    assign ra2     = instr_q[RM_LSB +: REG_ADDR_W];

    always_comb begin
        case (opcode)
            OP_AND, OP_EOR, OP_SUB, OP_RSB,
            OP_ADD, OP_ORR, OP_MOV, OP_MVN: supported = 1'b1;
            default:                        supported = 1'b0;
        endcase
    end

    // result of the instruction ahead wins over the stale register value
    assign opnd_a  = (wb_we && wb_rd == ra1) ? wb_data : rd1;
    assign opnd_rm = (wb_we && wb_rd == ra2) ? wb_data : rd2;

    ////////////////////////////////////////////////////////////////////////////
    // execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_we <= 1'b0;
        end else begin
            ex_we <= instr_valid_q && supported;
        end
    end

    always_ff @(posedge clk) begin
        ex_op          <= alu_op_t'(opcode);
        ex_set_flags   <= instr_q[SBIT];
        ex_rd          <= instr_q[RD_LSB +: REG_ADDR_W];
        ex_a           <= opnd_a;
        ex_b           <= imm_sel ? {{(DATA_W-IMM_W){1'b0}}, instr_q[IMM_W-1:0]} : opnd_rm;
        ex_shift       <= shift_t'(instr_q[SHTYPE_LSB +: 2]);
        ex_shamt       <= shamt;
        // only a register mov with a real shift goes through the shifter
        ex_use_shifter <= (opcode == OP_MOV) && !imm_sel && (shamt != '0);
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file import arm_dp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] ra1,
    input  logic [REG_ADDR_W-1:0] ra2,
    output logic [DATA_W-1:0]     rd1,
    output logic [DATA_W-1:0]     rd2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] wa,
    input  logic [DATA_W-1:0]     wd
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // single write port, lands on the clock edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // both reads are combinational
    // same-cycle writes are covered by forwarding in decode
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: rtl/arm_dp_pkg.sv
package arm_dp_pkg;

    // datapath sizes
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS   = 16;
    localparam int SHAMT_W    = 5;

    // data-processing instruction fields
    localparam int IMM_BIT    = 25;
    localparam int OPCODE_LSB = 21;
    localparam int SBIT       = 20;
    localparam int RN_LSB     = 16;
    localparam int RD_LSB     = 12;
    localparam int SHAMT_LSB  = 7;
    localparam int SHTYPE_LSB = 5;
    localparam int RM_LSB     = 0;
    localparam int IMM_W      = 8;

    // supported opcodes, ARM encodings
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_RSB = 4'b0011,
        OP_ADD = 4'b0100,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101,
        OP_MVN = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shift_t;

    // bit positions in the nzcv vector
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

endpackage
